/* design/controlDecode.sv */
// Combinational decoder from phase and instruction to datapath and memory control words
`timescale 1ns/1ps

module controlDecode
   import controlPkg::*;
(
   input  phaseT        phase,
   input  instrT        instr,
   input  logic         branchTaken,
   output datapathCtrlT datapathCtrl,
   output memCtrlT      memCtrl
);

   opcodeT     opcode;
   branchCodeT branchCode;
   intCodeT    intCode;
   datapathCtrlT dp;
   memCtrlT      mem;

   assign opcode = instr.opcode;
   assign branchCode = branchCodeT'(instr.cond);
   assign intCode = intCodeT'(instr.cond);
   assign datapathCtrl = dp;
   assign memCtrl = mem;

   always_comb begin
      dp = datapathIdle;
      mem = memIdle;
      case (phase.major)
         fetch: begin
            case (phase.sub)
               cycle0: begin
                  mem = '{ale: 1'b1, nWE: 1'b1, nOE: 1'b1, nME: 1'b1, default: 1'b0};
                  dp.pcEn = 1'b1;              // Address from the PC
               end
               cycle1: mem = '{nME: 1'b0, nWE: 1'b1, memEn: 1'b1, default: 1'b0};
               cycle2: mem = '{nME: 1'b0, nWE: 1'b1, memEn: 1'b1, enb: 1'b1, default: 1'b0};
               default: begin
                  mem = '{nME: 1'b1, nWE: 1'b1, memEn: 1'b1, default: 1'b0};
                  dp.irWe = 1'b1;
               end
            endcase
         end
         execute: begin
            case (phase.sub)
               cycle0: begin
                  case (opcode)
                     ADD, ADDI, SUB, SUBI, CMP, AND, OR, XOR, NOT: begin
                        dp.pcEn = 1'b1;
                        dp.pcWe = 1'b1;
                        dp.statusWe = 1'b1;
                        dp.regWe = (opcode != CMP);   // Compare only sets flags
                        case (opcode)
                           SUB, SUBI, CMP: dp.aluOp = FnSUB;
                           AND:     dp.aluOp = FnAND;
                           OR:      dp.aluOp = FnOR;
                           XOR:     dp.aluOp = FnXOR;
                           NOT:     dp.aluOp = FnNOT;
                           default: dp.aluOp = FnADD;
                        endcase
                        if (opcode inside {ADDI, SUBI}) dp.immSel = ImmShort;
                        else if (opcode != NOT) dp.op2Sel = Op2Rd2;
                     end
                     LUI, LLI: begin
                        dp.aluOp = (opcode == LUI) ? FnLUI : FnLLI;
                        dp.rs1Sel = Rs1Rd;
                        dp.aluEn = 1'b1;
                        dp.regWe = 1'b1;
                        dp.pcWe = 1'b1;
                     end
                     LDW, STW: begin           // Address add before it goes out
                        dp.immSel = ImmShort;
                        dp.aluEn = 1'b1;
                        dp.aluWe = 1'b1;
                     end
                     BRANCH: begin
                        dp.pcWe = 1'b1;
                        case (branchCode)
                           RET: begin
                              dp.lrEn = 1'b1;
                              dp.pcSel = PcSysbus;
                           end
                           JMP: begin
                              dp.immSel = ImmShort;
                              dp.pcSel = PcAluOut;
                           end
                           default: begin      // PC relative target
                              dp.op1Sel = Op1Pc;
                              dp.aluEn = 1'b1;
                              if (branchTaken) dp.pcSel = PcAluOut;
                              if (branchTaken && branchCode == BWL) begin
                                 dp.lrWe = 1'b1;
                                 dp.lrSel = LrPc;
                              end
                           end
                        endcase
                     end
                     INTERRUPT: begin
                        case (intCode)
                           RETI: begin         // Stack pointer to the ALU
                              dp.rs1Sel = Rs1Sp;
                              dp.op2Sel = Op2Zero;
                              dp.immSel = ImmShort;
                              dp.aluEn = 1'b1;
                              dp.aluWe = 1'b1;
                           end
                           EI, DI: begin
                              dp.pcEn = 1'b1;
                              dp.pcWe = 1'b1;
                              dp.intEnable = (intCode == EI);
                              dp.intDisable = (intCode == DI);
                           end
                           default: ;
                        endcase
                     end
                     default: ;
                  endcase
               end
               cycle1: begin                   // Address phase
                  mem = '{ale: 1'b1, nWE: 1'b1, nOE: 1'b1, nME: 1'b1, default: 1'b0};
                  dp.aluEn = 1'b1;
                  if (opcode == INTERRUPT) begin
                     dp.rs1Sel = Rs1Sp;
                     dp.op2Sel = Op2Zero;
                  end else begin
                     dp.immSel = ImmShort;
                  end
               end
               cycle2: begin
                  mem = '{nME: 1'b0, nWE: 1'b1, memEn: (opcode != STW), nOE: (opcode != INTERRUPT),
                          default: 1'b0};
                  dp.op2Sel = Op2Zero;
                  dp.aluEn = 1'b1;
                  dp.aluWe = (opcode != INTERRUPT);
                  dp.rs1Sel = (opcode == INTERRUPT) ? Rs1Sp : Rs1Rd;   // Store data or stack
               end
               cycle3: begin
                  if (opcode == STW) begin     // Hold write data on the bus
                     mem = '{nME: 1'b0, nOE: 1'b1, default: 1'b0};
                     dp.aluEn = 1'b1;
                     dp.op2Sel = Op2Zero;
                  end else begin
                     mem = '{nME: 1'b0, memEn: 1'b1, enb: 1'b1, nWE: 1'b1, default: 1'b0};
                  end
               end
               default: begin
                  dp.pcWe = 1'b1;
                  case (opcode)
                     LDW: begin
                        mem = '{nME: 1'b1, nWE: 1'b1, memEn: 1'b1, default: 1'b0};
                        dp.wdSel = WdSys;
                        dp.regWe = 1'b1;
                     end
                     STW: begin
                        mem = '{nME: 1'b1, nOE: 1'b1, default: 1'b0};
                        dp.aluEn = 1'b1;
                        dp.op2Sel = Op2Zero;
                     end
                     default: begin            // RETI pops the PC and bumps the SP
                        mem = '{nME: 1'b1, nWE: 1'b1, memEn: 1'b1, default: 1'b0};
                        dp.pcSel = PcSysbus;
                        dp.rs1Sel = Rs1Sp;
                        dp.op2Sel = Op2Zero;
                        dp.aluOp = FnINC;
                        dp.rwSel = RwSp;
                        dp.regWe = 1'b1;
                        dp.leaveIsr = 1'b1;
                     end
                  endcase
               end
            endcase
         end
         default: begin
            case (phase.sub)
               cycle0: begin                   // Pre-decrement the stack pointer
                  dp.rs1Sel = Rs1Sp;
                  dp.aluOp = FnDEC;
                  dp.op2Sel = Op2Zero;
                  dp.rwSel = RwSp;
                  dp.regWe = 1'b1;
                  dp.aluWe = 1'b1;
                  dp.aluEn = 1'b1;
               end
               cycle1: begin
                  mem = '{ale: 1'b1, nWE: 1'b1, nOE: 1'b1, nME: 1'b1, default: 1'b0};
                  dp.rs1Sel = Rs1Sp;
                  dp.aluOp = FnDEC;
                  dp.op2Sel = Op2Zero;
                  dp.aluEn = 1'b1;
               end
               cycle2: begin
                  mem = '{nME: 1'b0, nWE: 1'b1, nOE: 1'b1, default: 1'b0};
                  dp.op2Sel = Op2Zero;
                  dp.aluEn = 1'b1;
               end
               cycle3: begin                   // Return address on the bus
                  mem = '{nME: 1'b0, nOE: 1'b1, default: 1'b0};
                  dp.pcEn = 1'b1;
               end
               default: begin
                  mem = '{nME: 1'b1, nOE: 1'b1, default: 1'b0};
                  dp.pcEn = 1'b1;
                  dp.pcSel = PcInt;
                  dp.pcWe = 1'b1;
                  dp.intClear = 1'b1;
               end
            endcase
         end
      endcase
      assert (!(dp.pcWe && dp.irWe));          // The PC never moves under an IR load
   end

endmodule

/* design/controlPkg.sv */
// Control unit opcodes, state and selector enums, control structs and idle control words
package controlPkg;

   typedef enum logic [4:0] {
      ADD, ADDI, SUB, SUBI, CMP, AND, OR, XOR, NOT, LUI, LLI,
      LDW, STW, BRANCH, INTERRUPT
   } opcodeT;

   typedef enum logic [2:0] {BR, BNE, BE, BLT, BGE, BWL, RET, JMP} branchCodeT;

   typedef enum logic [2:0] {RETI, EI, DI} intCodeT;   // Cond field under INTERRUPT

   typedef enum logic [1:0] {fetch, execute, interrupt} majorStateT;

   typedef enum logic [2:0] {cycle0, cycle1, cycle2, cycle3, cycle4} subCycleT;

   typedef enum logic [3:0] {
      FnADD, FnSUB, FnAND, FnOR, FnXOR, FnNOT, FnLUI, FnLLI, FnINC, FnDEC
   } aluFnT;

   typedef enum logic       {Op1Rd1, Op1Pc} op1SelT;
   typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2SelT;
   typedef enum logic       {ImmLong, ImmShort} immSelT;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSelT;
   typedef enum logic       {WdAlu, WdSys} wdSelT;
   typedef enum logic       {RwRd, RwSp} rwSelT;                // RwSp for the stack pointer
   typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Sp} rs1SelT;
   typedef enum logic       {LrSys, LrPc} lrSelT;

   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] cond;                                          // Branch or interrupt code
   } instrT;

   typedef struct packed {
      logic z;
      logic n;
      logic v;
      logic c;
   } flagsT;

   typedef struct packed {
      majorStateT major;
      subCycleT   sub;
   } phaseT;

   typedef struct packed {
      aluFnT  aluOp;
      op1SelT op1Sel;
      op2SelT op2Sel;
      immSelT immSel;
      pcSelT  pcSel;
      wdSelT  wdSel;
      rwSelT  rwSel;
      rs1SelT rs1Sel;
      lrSelT  lrSel;
      logic   aluEn;
      logic   aluWe;
      logic   lrEn;
      logic   lrWe;
      logic   pcWe;
      logic   pcEn;
      logic   irWe;
      logic   regWe;
      logic   statusWe;
      logic   intEnable;
      logic   intDisable;
      logic   intClear;
      logic   leaveIsr;
   } datapathCtrlT;

   typedef struct packed {
      logic memEn;
      logic nWE;
      logic nOE;
      logic nME;
      logic enb;
      logic ale;
   } memCtrlT;

   localparam datapathCtrlT datapathIdle = '{
      aluOp: FnADD, op1Sel: Op1Rd1, op2Sel: Op2Imm, immSel: ImmLong, pcSel: Pc1,
      wdSel: WdAlu, rwSel: RwRd, rs1Sel: Rs1Ra, lrSel: LrSys, default: 1'b0
   };

   localparam memCtrlT memIdle = '{nME: 1'b1, default: 1'b0};   // Memory deselected

endpackage

/* design/controlUnit.sv */
// Control unit top level joining the interrupt, flag, sequencer and decoder blocks
`timescale 1ns/1ps

module controlUnit
   import controlPkg::*;
#(
   parameter int SyncStages = 2
) (
   input  logic         Clock,
   input  logic         nReset,
   input  instrT        instr,
   input  flagsT        aluFlags,
   input  logic         nWait,
   input  logic         nIRQ,
   output datapathCtrlT datapathCtrl,
   output memCtrlT      memCtrl,
   output logic         carryFlag
);

   logic  intReq;
   logic  enterIsr;
   logic  branchTaken;
   phaseT phase;

   irqSync #(.SyncStages(SyncStages)) u_irqSync (
      .Clock      (Clock),
      .nReset     (nReset),
      .nIRQ       (nIRQ),
      .intEnable  (datapathCtrl.intEnable),
      .intDisable (datapathCtrl.intDisable),
      .intClear   (datapathCtrl.intClear),
      .enterIsr   (enterIsr),
      .leaveIsr   (datapathCtrl.leaveIsr),    // RETI done
      .intReq     (intReq)
   );

   statusFlags u_statusFlags (
      .Clock       (Clock),
      .nReset      (nReset),
      .aluFlags    (aluFlags),
      .statusWe    (datapathCtrl.statusWe),
      .instr       (instr),
      .branchTaken (branchTaken),
      .carryFlag   (carryFlag)
   );

   cycleSequencer u_cycleSequencer (
      .Clock    (Clock),
      .nReset   (nReset),
      .instr    (instr),
      .nWait    (nWait),
      .intReq   (intReq),
      .phase    (phase),
      .enterIsr (enterIsr)
   );

   controlDecode u_controlDecode (
      .phase        (phase),
      .instr        (instr),
      .branchTaken  (branchTaken),
      .datapathCtrl (datapathCtrl),
      .memCtrl      (memCtrl)
   );

endmodule

/* design/cycleSequencer.sv */
// Major state and sub-cycle sequencer with memory wait stalls
`timescale 1ns/1ps

module cycleSequencer
   import controlPkg::*;
(
   input  logic  Clock,
   input  logic  nReset,
   input  instrT instr,
   input  logic  nWait,
   input  logic  intReq,
   output phaseT phase,
   output logic  enterIsr
);

   logic       multiCycle;   // LDW, STW and RETI use the memory path
   majorStateT afterInstr;
   subCycleT   nextSub;

   assign multiCycle = (instr.opcode inside {LDW, STW}) ||
                       (instr.opcode == INTERRUPT && intCodeT'(instr.cond) == RETI);
   assign afterInstr = intReq ? interrupt : fetch;
   assign nextSub = subCycleT'(phase.sub + 3'd1);
   assign enterIsr = (phase.major == interrupt) && (phase.sub == cycle0);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         phase <= '{major: fetch, sub: cycle0};
      end else begin
         case (phase.major)
            fetch: begin
               if (phase.sub == cycle3) begin
                  phase <= '{major: execute, sub: cycle0};
               end else if (phase.sub != cycle2 || nWait) begin   // Instruction read stall
                  phase.sub <= nextSub;
               end
            end
            execute: begin
               if ((phase.sub == cycle0 && !multiCycle) || phase.sub == cycle4) begin
                  phase <= '{major: afterInstr, sub: cycle0};
               end else if (phase.sub != cycle3 || nWait) begin   // Data setup stall
                  phase.sub <= nextSub;
               end
            end
            default: begin
               // Entry always runs five cycles
               if (phase.sub == cycle4) begin
                  phase <= '{major: fetch, sub: cycle0};
               end else begin
                  phase.sub <= nextSub;
               end
            end
         endcase
      end
   end

   fetchNoCycle4: assert property (@(posedge Clock) disable iff (!nReset)
      phase.major == fetch |-> phase.sub != cycle4);

endmodule

/* design/irqSync.sv */
// Interrupt request synchroniser, pending latch, in-service flag and enable flag
`timescale 1ns/1ps

module irqSync #(
   parameter int SyncStages = 2
) (
   input  logic Clock,
   input  logic nReset,
   input  logic nIRQ,
   input  logic intEnable,
   input  logic intDisable,
   input  logic intClear,
   input  logic enterIsr,
   input  logic leaveIsr,
   output logic intReq
);

   logic [SyncStages-1:0] irqChain;   // Active high request, oldest at the top
   logic                  syncLevel;
   logic                  levelDly;   // For the rising edge
   logic                  pending;
   logic                  inIsr;
   logic                  enabled;

   assign syncLevel = irqChain[SyncStages-1];
   assign intReq = pending & enabled;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         irqChain <= '0;
         levelDly <= 1'b0;
         pending <= 1'b0;
         inIsr <= 1'b0;
         enabled <= 1'b0;
      end else begin
         irqChain <= {irqChain[SyncStages-2:0], ~nIRQ};
         levelDly <= syncLevel;
         // A fresh edge may nest, a held level only counts outside the ISR
         pending <= (syncLevel & ~inIsr) | (syncLevel & ~levelDly) | (pending & ~intClear);
         if (enterIsr) inIsr <= 1'b1;
         else if (leaveIsr) inIsr <= 1'b0;
         if (intEnable) enabled <= 1'b1;     // EI
         else if (intDisable) enabled <= 1'b0;   // DI
      end
   end

   enableDisableExclusive: assert property (@(posedge Clock) disable iff (!nReset)
      !(intEnable && intDisable));

endmodule

/* design/statusFlags.sv */
// Status flag register and branch condition evaluator
`timescale 1ns/1ps

module statusFlags
   import controlPkg::*;
(
   input  logic  Clock,
   input  logic  nReset,
   input  flagsT aluFlags,
   input  logic  statusWe,
   input  instrT instr,
   output logic  branchTaken,
   output logic  carryFlag
);

   flagsT      statusReg;
   branchCodeT branchCode;

   assign branchCode = branchCodeT'(instr.cond);
   assign carryFlag = statusReg.c;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (statusWe) begin
         statusReg <= aluFlags;
      end
   end

   always_comb begin
      case (branchCode)
         BR, BWL: branchTaken = 1'b1;
         BNE:     branchTaken = ~statusReg.z;
         BE:      branchTaken = statusReg.z;
         BLT:     branchTaken = statusReg.n ^ statusReg.v;    // Signed less than
         BGE:     branchTaken = ~(statusReg.n ^ statusReg.v);
         default: branchTaken = 1'b0;                         // RET and JMP decoded apart
      endcase
   end

endmodule

/* include/controlChecks.svh */
// Compare tasks for control words and single bits and the result counters
`ifndef CONTROL_CHECKS_SVH
`define CONTROL_CHECKS_SVH

int checksPassed = 0;
int checksFailed = 0;

task automatic checkDatapath(input string testName, input datapathCtrlT expected,
                             input datapathCtrlT actual);
   if (actual !== expected) begin
      checksFailed++;
      $display("FAILED %s datapathCtrl expected %h actual %h", testName, expected, actual);
   end else begin
      checksPassed++;
   end
endtask

task automatic checkMem(input string testName, input memCtrlT expected, input memCtrlT actual);
   if (actual !== expected) begin
      checksFailed++;
      $display("FAILED %s memCtrl expected %b actual %b", testName, expected, actual);
   end else begin
      checksPassed++;
   end
endtask

task automatic checkBit(input string testName, input logic expected, input logic actual);
   if (actual !== expected) begin
      checksFailed++;
      $display("FAILED %s expected %b actual %b", testName, expected, actual);
   end else begin
      checksPassed++;
   end
endtask

`endif

/* dv/controlUnitTb.sv */
// Control unit testbench with clock, reset, stimulus table, apply loop and watchdog
`timescale 1ns/1ps

module controlUnitTb
   import controlPkg::*;
();

`include "controlChecks.svh"

   localparam int ClockPeriod = 40;

   logic         Clock;
   logic         nReset;
   instrT        instr;
   flagsT        aluFlags;
   logic         nWait;
   logic         nIRQ;
   datapathCtrlT datapathCtrl;
   memCtrlT      memCtrl;
   logic         carryFlag;

   typedef struct {
      string        name;
      instrT        instr;
      flagsT        flags;
      logic         irq;     // nIRQ low through the row
      datapathCtrlT exp;     // Execute cycle0 view
      logic         carry;   // Carry after the instruction
   } rowT;

   rowT  rows[$];
   logic irqEnabled;   // Reference interrupt state
   logic irqPending;

   controlUnit #(.SyncStages(2)) u_controlUnit (
      .Clock        (Clock),
      .nReset       (nReset),
      .instr        (instr),
      .aluFlags     (aluFlags),
      .nWait        (nWait),
      .nIRQ         (nIRQ),
      .datapathCtrl (datapathCtrl),
      .memCtrl      (memCtrl),
      .carryFlag    (carryFlag)
   );

   initial begin
      Clock = 1'b0;
      forever #(ClockPeriod / 2) Clock = ~Clock;
   end

   function automatic datapathCtrlT ctl(aluFnT aluOp, op2SelT op2Sel, pcSelT pcSel,
                                        logic regWe, logic pcWe, logic lrWe);
      datapathCtrlT d;
      d = datapathIdle;
      d.aluOp = aluOp;
      d.op2Sel = op2Sel;
      d.pcSel = pcSel;
      d.regWe = regWe;
      d.pcWe = pcWe;
      d.lrWe = lrWe;
      return d;
   endfunction

   function automatic datapathCtrlT execView(datapathCtrlT d);
      return ctl(d.aluOp, d.op2Sel, d.pcSel, d.regWe, d.pcWe, d.lrWe);
   endfunction

   function automatic memCtrlT memWord(logic ale, logic nME, logic enb);
      memCtrlT m;
      m = memIdle;
      m.ale = ale;
      m.nME = nME;
      m.enb = enb;
      return m;
   endfunction

   function automatic memCtrlT memView(memCtrlT m);
      return memWord(m.ale, m.nME, m.enb);
   endfunction

   function automatic logic writeStrobes(datapathCtrlT d);
      return d.aluWe | d.lrWe | d.pcWe | d.irWe | d.regWe | d.statusWe;
   endfunction

   function automatic void addRow(string name, opcodeT op, logic [2:0] cond, flagsT flags,
                                  logic irq, datapathCtrlT exp, logic carry);
      rowT r;
      r.name = name;
      r.instr = '{opcode: op, cond: cond};
      r.flags = flags;
      r.irq = irq;
      r.exp = exp;
      r.carry = carry;
      rows.push_back(r);
   endfunction

   function automatic void buildTable();
      addRow("add", ADD, 3'd0, 4'b0001, 1'b0, ctl(FnADD, Op2Rd2, Pc1, 1'b1, 1'b1, 1'b0), 1'b1);
      addRow("addi", ADDI, 3'd0, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, Pc1, 1'b1, 1'b1, 1'b0), 1'b0);
      addRow("sub", SUB, 3'd0, 4'b0011, 1'b0, ctl(FnSUB, Op2Rd2, Pc1, 1'b1, 1'b1, 1'b0), 1'b1);
      addRow("subi", SUBI, 3'd0, 4'b0100, 1'b0, ctl(FnSUB, Op2Imm, Pc1, 1'b1, 1'b1, 1'b0), 1'b0);
      addRow("and", AND, 3'd0, 4'b0001, 1'b0, ctl(FnAND, Op2Rd2, Pc1, 1'b1, 1'b1, 1'b0), 1'b1);
      addRow("or", OR, 3'd0, 4'b0000, 1'b0, ctl(FnOR, Op2Rd2, Pc1, 1'b1, 1'b1, 1'b0), 1'b0);
      addRow("xor", XOR, 3'd0, 4'b0001, 1'b0, ctl(FnXOR, Op2Rd2, Pc1, 1'b1, 1'b1, 1'b0), 1'b1);
      addRow("not", NOT, 3'd0, 4'b0100, 1'b0, ctl(FnNOT, Op2Imm, Pc1, 1'b1, 1'b1, 1'b0), 1'b0);
      addRow("lui", LUI, 3'd0, 4'b1111, 1'b0, ctl(FnLUI, Op2Imm, Pc1, 1'b1, 1'b1, 1'b0), 1'b0);
      addRow("lli", LLI, 3'd0, 4'b1111, 1'b0, ctl(FnLLI, Op2Imm, Pc1, 1'b1, 1'b1, 1'b0), 1'b0);
      addRow("cmpEq", CMP, 3'd0, 4'b1001, 1'b0, ctl(FnSUB, Op2Rd2, Pc1, 1'b0, 1'b1, 1'b0), 1'b1);
      // Z set, N equals V
      addRow("br", BRANCH, BR, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, PcAluOut, 1'b0, 1'b1, 1'b0), 1'b1);
      addRow("bne", BRANCH, BNE, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, Pc1, 1'b0, 1'b1, 1'b0), 1'b1);
      addRow("be", BRANCH, BE, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, PcAluOut, 1'b0, 1'b1, 1'b0), 1'b1);
      addRow("blt", BRANCH, BLT, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, Pc1, 1'b0, 1'b1, 1'b0), 1'b1);
      addRow("bge", BRANCH, BGE, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, PcAluOut, 1'b0, 1'b1, 1'b0), 1'b1);
      addRow("bwl", BRANCH, BWL, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, PcAluOut, 1'b0, 1'b1, 1'b1), 1'b1);
      addRow("ret", BRANCH, RET, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, PcSysbus, 1'b0, 1'b1, 1'b0), 1'b1);
      addRow("jmp", BRANCH, JMP, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, PcAluOut, 1'b0, 1'b1, 1'b0), 1'b1);
      addRow("cmpLt", CMP, 3'd0, 4'b0100, 1'b0, ctl(FnSUB, Op2Rd2, Pc1, 1'b0, 1'b1, 1'b0), 1'b0);
      // Z clear, N differs from V
      addRow("bneLt", BRANCH, BNE, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, PcAluOut, 1'b0, 1'b1, 1'b0), 1'b0);
      addRow("beLt", BRANCH, BE, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, Pc1, 1'b0, 1'b1, 1'b0), 1'b0);
      addRow("bltLt", BRANCH, BLT, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, PcAluOut, 1'b0, 1'b1, 1'b0), 1'b0);
      addRow("bgeLt", BRANCH, BGE, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, Pc1, 1'b0, 1'b1, 1'b0), 1'b0);
      addRow("bwlLt", BRANCH, BWL, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, PcAluOut, 1'b0, 1'b1, 1'b1), 1'b0);
      addRow("ldw", LDW, 3'd0, 4'b1111, 1'b0, ctl(FnADD, Op2Imm, Pc1, 1'b0, 1'b0, 1'b0), 1'b0);
      addRow("stw", STW, 3'd0, 4'b1111, 1'b0, ctl(FnADD, Op2Imm, Pc1, 1'b0, 1'b0, 1'b0), 1'b0);
      addRow("noEi", ADD, 3'd0, 4'b0001, 1'b1, ctl(FnADD, Op2Rd2, Pc1, 1'b1, 1'b1, 1'b0), 1'b1);
      addRow("ei", INTERRUPT, EI, 4'b0000, 1'b1, ctl(FnADD, Op2Imm, Pc1, 1'b0, 1'b1, 1'b0), 1'b1);
      addRow("isrEntry", ADD, 3'd0, 4'b0000, 1'b1, ctl(FnADD, Op2Rd2, Pc1, 1'b1, 1'b1, 1'b0), 1'b0);
      addRow("reti", INTERRUPT, RETI, 4'b0000, 1'b0, ctl(FnADD, Op2Zero, Pc1, 1'b0, 1'b0, 1'b0), 1'b0);
      addRow("di", INTERRUPT, DI, 4'b0000, 1'b0, ctl(FnADD, Op2Imm, Pc1, 1'b0, 1'b1, 1'b0), 1'b0);
      addRow("irqMasked", ADD, 3'd0, 4'b0001, 1'b1, ctl(FnADD, Op2Rd2, Pc1, 1'b1, 1'b1, 1'b0), 1'b1);
   endfunction

   task automatic nextCycle();   // Inputs change just after the edge
      @(posedge Clock);
      #2;
   endtask

   task automatic midCycle();
      @(negedge Clock);
   endtask

   // Starts at the middle of fetch cycle0, ends just after the edge into execute
   task automatic fetchSequence(string name, logic irq, int stall);
      checkMem({name, " fetch0"}, memWord(1'b1, 1'b1, 1'b0), memView(memCtrl));
      nextCycle();
      nIRQ = ~irq;
      midCycle();
      checkMem({name, " fetch1"}, memWord(1'b0, 1'b0, 1'b0), memView(memCtrl));
      nextCycle();
      for (int k = 0; k <= stall; k++) begin
         nWait = (k == stall);                  // Memory ready on the last one
         midCycle();
         checkMem({name, " fetch2"}, memWord(1'b0, 1'b0, 1'b1), memView(memCtrl));
         checkBit({name, " irWe early"}, 1'b0, datapathCtrl.irWe);
         nextCycle();
      end
      midCycle();
      checkBit({name, " irWe"}, 1'b1, datapathCtrl.irWe);
      nextCycle();
   endtask

   task automatic memoryAccess(rowT r, int stall);
      logic isLoad;
      logic isStore;
      logic isRet;
      int   waits;
      isLoad = (r.instr.opcode == LDW);
      isStore = (r.instr.opcode == STW);
      isRet = (r.instr.opcode == INTERRUPT);
      waits = isRet ? 0 : stall;
      midCycle();
      checkMem({r.name, " mem1"}, memWord(1'b1, 1'b1, 1'b0), memView(memCtrl));
      nextCycle();
      midCycle();
      checkMem({r.name, " mem2"}, memWord(1'b0, 1'b0, 1'b0), memView(memCtrl));
      nextCycle();
      for (int k = 0; k <= waits; k++) begin
         nWait = (k == waits);
         midCycle();
         checkBit({r.name, " mem3 nME"}, 1'b0, memCtrl.nME);
         checkBit({r.name, " early regWe"}, 1'b0, datapathCtrl.regWe);
         if (k == waits) checkBit({r.name, " mem3 enb"}, ~isStore, memCtrl.enb);
         nextCycle();
      end
      midCycle();
      if (!isRet) checkBit({r.name, " regWe"}, isLoad, datapathCtrl.regWe);
      if (isLoad) checkBit({r.name, " WdSys"}, 1'b1, datapathCtrl.wdSel == WdSys);
      if (isRet) begin
         checkBit({r.name, " PcSysbus"}, 1'b1, datapathCtrl.pcSel == PcSysbus);
         checkBit({r.name, " leaveIsr"}, 1'b1, datapathCtrl.leaveIsr);
      end
      nextCycle();
   endtask

   task automatic interruptEntry(string name);
      for (int k = 0; k < 5; k++) begin
         checkBit({name, " isr pcWe"}, k == 4, datapathCtrl.pcWe);
         if (k == 4) begin
            checkBit({name, " isr PcInt"}, 1'b1, datapathCtrl.pcSel == PcInt);
            checkBit({name, " isr intClear"}, 1'b1, datapathCtrl.intClear);
         end
         nextCycle();
         midCycle();
      end
   endtask

   task automatic applyRow(rowT r, int stall);
      logic    multi;
      logic    expectIsr;
      intCodeT code;
      code = intCodeT'(r.instr.cond);
      multi = (r.instr.opcode inside {LDW, STW}) || (r.instr.opcode == INTERRUPT && code == RETI);
      expectIsr = irqEnabled && (irqPending || r.irq);   // Enable must predate the row
      fetchSequence(r.name, r.irq, stall);
      instr = r.instr;                                   // IR now holds the new word
      aluFlags = r.flags;
      midCycle();
      checkDatapath({r.name, " execute"}, r.exp, execView(datapathCtrl));
      nextCycle();
      if (multi) memoryAccess(r, stall);
      midCycle();
      checkBit({r.name, " carry"}, r.carry, carryFlag);
      checkBit({r.name, " isr entry"}, expectIsr, ~memCtrl.ale);
      if (expectIsr) interruptEntry(r.name);
      if (r.irq) irqPending = 1'b1;
      if (expectIsr) irqPending = 1'b0;
      if (r.instr.opcode == INTERRUPT && code == EI) irqEnabled = 1'b1;
      if (r.instr.opcode == INTERRUPT && code == DI) irqEnabled = 1'b0;
   endtask

   initial begin
      void'($urandom(18071));
      buildTable();
      nReset = 1'b0;
      instr = '{opcode: ADD, cond: 3'd0};
      aluFlags = '0;
      nWait = 1'b1;
      nIRQ = 1'b1;
      irqEnabled = 1'b0;
      irqPending = 1'b0;
      repeat (4) @(posedge Clock);
      nextCycle();                   // Fifth edge under reset
      nReset = 1'b1;
      midCycle();
      checkMem("reset mem", memWord(1'b1, 1'b1, 1'b0), memView(memCtrl));
      checkBit("reset strobes", 1'b0, writeStrobes(datapathCtrl));
      foreach (rows[i]) begin
         int failsBefore;
         failsBefore = checksFailed;
         applyRow(rows[i], $urandom_range(0, 3));
         $display("Test %s %s", rows[i].name, (checksFailed == failsBefore) ? "ok" : "error");
      end
      $display("Tests %0d, checks passed %0d, checks failed %0d", rows.size(), checksPassed,
               checksFailed);
      if (checksFailed == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Twenty cycles covers the longest row with stalls and an interrupt entry
   initial begin
      #1;
      #((rows.size() * 20 + 100) * ClockPeriod);
      $display("Timeout: the test sequence did not complete in time");
      $display("Regression failed");
      $finish;
   end

endmodule

/* run.sh */
#!/bin/sh
# Compile the control unit testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module controlUnitTb \
   -f sim.f -o controlUnitSim

./obj_dir/controlUnitSim | tee sim.log

if grep -q "Regression failed" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
if ! grep -q "Regression passed" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"

/* sim.f */
+incdir+include
design/controlPkg.sv
design/irqSync.sv
design/statusFlags.sv
design/cycleSequencer.sv
design/controlDecode.sv
design/controlUnit.sv
dv/controlUnitTb.sv
